// ==== files.f ====
common/icache_pkg.sv
hdl/flush_counter.sv
cache_arrays/tag_store.sv
cache_arrays/data_store.sv
cache_arrays/plru_tree.sv
icache_ctrl/icache_ctrl.sv
hdl/icache_top.sv
testbench/icache_chk.sv
testbench/tb_icache_top.sv

// ==== Makefile ====
# Verilator flow for the instruction cache testbench
# The simulator exit status carries pass or fail

TOOL       := verilator
TOP        := tb_icache_top
FILE_LIST  := files.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

# Static checks of the RTL and the testbench
lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# Build the executable, then run it
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_icache_top.sv ====
// Testbench for the instruction cache that drives CPU reads and answers line refills
// Checks words, miss flags and sweep timing against its own valid and PLRU model
`timescale 1ns/1ps
`default_nettype none

module tb_icache_top;

  localparam int          TIMEOUT_CYC = 100;
  localparam int          HIT_LAT     = 2;
  localparam logic [31:0] WORD_KEY    = 32'hA5A5_0000;
  localparam logic [31:0] SEED        = 32'h1be8_6ec2;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 cpu_req_valid;
  icache_pkg::cpu_req_t cpu_req;
  logic                 cpu_ack;
  icache_pkg::cpu_rsp_t cpu_rsp;
  logic                 mem_req_valid;
  icache_pkg::mem_req_t mem_req;
  logic                 mem_ack = 1'b0;
  icache_pkg::line_t    mem_line = '0;
  logic                 flush;
  logic                 flush_busy;

  // Memory model state
  logic                 mem_busy = 1'b0;
  int                   mem_wait = 0;
  int                   mem_req_count = 0;
  icache_pkg::addr_t    mem_last_addr = '0;

  // Cache model with tree bits [0] root, [1] ways 0/1 and [2] ways 2/3
  icache_pkg::way_vec_t   m_valid [icache_pkg::NUM_SET];
  icache_pkg::tag_t       m_tag   [icache_pkg::NUM_SET][icache_pkg::NUM_WAY];
  icache_pkg::plru_node_t m_tree  [icache_pkg::NUM_SET];

  always #5 clk = ~clk;

  icache_top dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .cpu_req_valid_i(cpu_req_valid),
    .cpu_req_i      (cpu_req),
    .cpu_ack_o      (cpu_ack),
    .cpu_rsp_o      (cpu_rsp),
    .mem_req_valid_o(mem_req_valid),
    .mem_req_o      (mem_req),
    .mem_ack_i      (mem_ack),
    .mem_line_i     (mem_line),
    .flush_i        (flush),
    .flush_busy_o   (flush_busy)
  );

  bind icache_top icache_chk chk_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cpu_req_valid_i(cpu_req_valid_i),
    .cpu_ack_i      (cpu_ack_o),
    .mem_req_valid_i(mem_req_valid_o),
    .mem_ack_i      (mem_ack_i),
    .flush_busy_i   (flush_busy_o)
  );

  // ==============================
  // Memory model
  // ==============================
  // Word k of a line holds its own byte address XOR the key
  function automatic icache_pkg::line_t make_line(input icache_pkg::addr_t base);
    icache_pkg::line_t line;
    for (int k = 0; k < icache_pkg::LINE_W / icache_pkg::WORD_W; k++) begin
      line[k*icache_pkg::WORD_W +: icache_pkg::WORD_W] = (base + 32'(4 * k)) ^ WORD_KEY;
    end
    return line;
  endfunction

  // Random ack delay with the ack held until the request drops
  always @(negedge clk) begin
    if (!rst_n) begin
      mem_ack  <= 1'b0;
      mem_busy <= 1'b0;
    end else if (mem_ack) begin
      if (!mem_req_valid) begin
        mem_ack <= 1'b0;
      end
    end else if (mem_busy) begin
      if (mem_wait == 0) begin
        mem_ack  <= 1'b1;
        mem_line <= make_line(mem_last_addr);
        mem_busy <= 1'b0;
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (mem_req_valid) begin
      mem_busy      <= 1'b1;
      mem_wait      <= int'($urandom % 4);
      mem_last_addr <= mem_req.line_addr;
      mem_req_count <= mem_req_count + 1;
    end
  end

  // ==============================
  // Cache model
  // ==============================
  // Bit 0 in a node selects the left half or the lower way
  function automatic logic [1:0] pick_victim_way(input icache_pkg::plru_node_t bits);
    if (!bits[0]) begin
      return bits[1] ? 2'd1 : 2'd0;
    end
    return bits[2] ? 2'd3 : 2'd2;
  endfunction

  // Nodes on the path point away from the used way
  function automatic icache_pkg::plru_node_t mark_way_used(input icache_pkg::plru_node_t bits,
                                                           input logic [1:0] way);
    icache_pkg::plru_node_t nxt;
    nxt = bits;
    if (way < 2'd2) begin
      nxt[0] = 1'b1;
      nxt[1] = (way == 2'd0);
    end else begin
      nxt[0] = 1'b0;
      nxt[2] = (way == 2'd2);
    end
    return nxt;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < icache_pkg::NUM_SET; s++) begin
      m_valid[s] = '0;
      m_tree[s]  = '0;
    end
  endtask

  // Predicts hit or miss, then applies the fill and the touch
  task automatic model_access(input icache_pkg::addr_t addr, output logic miss);
    icache_pkg::idx_t set;
    icache_pkg::tag_t tag;
    logic [1:0]       way;
    logic             found;
    set   = addr[icache_pkg::BYTE_OFF_W +: icache_pkg::IDX_W];
    tag   = addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    found = 1'b0;
    way   = 2'd0;
    for (int w = 0; w < icache_pkg::NUM_WAY; w++) begin
      if (m_valid[set][w] && m_tag[set][w] == tag) begin
        found = 1'b1;
        way   = 2'(w);
      end
    end
    miss = !found;
    if (miss) begin
      // Lowest invalid way beats the tree
      way = pick_victim_way(m_tree[set]);
      for (int w = icache_pkg::NUM_WAY - 1; w >= 0; w--) begin
        if (!m_valid[set][w]) begin
          way = 2'(w);
        end
      end
      m_valid[set][way] = 1'b1;
      m_tag[set][way]   = tag;
    end
    m_tree[set] = mark_way_used(m_tree[set], way);
  endtask

  // ==============================
  // Checks and waits
  // ==============================
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      stop_run($sformatf("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      stop_run($sformatf("** Error %s: expected %0b, actual %0b", name, exp, act));
    end
  endtask

  // Counts rising edges until the CPU ack reaches the level
  task automatic wait_ack(input logic level, input string name, output int cycles);
    cycles = 0;
    while (cpu_ack !== level) begin
      if (cycles >= TIMEOUT_CYC) begin
        stop_run($sformatf("Timeout: CPU ack never went to %0b in %s", level, name));
      end
      @(posedge clk);
      @(negedge clk);
      cycles++;
    end
  endtask

  // Sweep length in cycles with both handshakes quiet throughout
  task automatic measure_sweep(input string name, output int cycles);
    cycles = 0;
    while (flush_busy) begin
      if (cycles >= TIMEOUT_CYC) begin
        stop_run($sformatf("Timeout: sweep never ended in %s", name));
      end
      @(posedge clk);
      @(negedge clk);
      cycles++;
      check_bit({name, " cpu ack"}, 1'b0, cpu_ack);
      check_bit({name, " memory request"}, 1'b0, mem_req_valid);
    end
  endtask

  // One full four-phase read, checked against the model
  task automatic cpu_read(input string name, input icache_pkg::addr_t addr, output logic miss);
    logic exp_miss;
    int   cycles;
    int   req_before;
    model_access(addr, exp_miss);
    req_before    = mem_req_count;
    cpu_req_valid = 1'b1;
    cpu_req.addr  = addr;
    wait_ack(1'b1, name, cycles);
    miss = cpu_rsp.miss;
    check_eq({name, " data"}, {addr[31:2], 2'b00} ^ WORD_KEY, cpu_rsp.data);
    check_bit({name, " miss"}, exp_miss, cpu_rsp.miss);
    check_eq({name, " memory requests"}, 32'(exp_miss), mem_req_count - req_before);
    if (exp_miss) begin
      check_eq({name, " line address"}, {addr[31:4], 4'h0}, mem_last_addr);
    end else begin
      // First counted edge only samples the request
      check_eq({name, " hit latency"}, 32'(HIT_LAT + 1), cycles);
    end
    cpu_req_valid = 1'b0;
    wait_ack(1'b0, name, cycles);
  endtask

  // Lines of set 5 that differ only in the tag
  function automatic icache_pkg::addr_t set5_line(input int n);
    return 32'h0001_0054 + (32'(n) << 12);
  endfunction

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    logic miss;
    int   cycles;
    void'($urandom(SEED));
    rst_n         = 1'b0;
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    flush         = 1'b0;
    clear_model();
    repeat (4) @(negedge clk);
    check_bit("reset cpu ack", 1'b0, cpu_ack);
    check_bit("reset memory request", 1'b0, mem_req_valid);
    rst_n = 1'b1;

    // Sweep after reset
    measure_sweep("reset sweep", cycles);
    check_eq("reset sweep length", icache_pkg::NUM_SET, cycles);

    // New line followed by hits across the same line
    cpu_read("first read", 32'h0000_1234, miss);
    check_bit("first read is a miss", 1'b1, miss);
    cpu_read("same word", 32'h0000_1234, miss);
    cpu_read("next word", 32'h0000_1238, miss);
    cpu_read("last word", 32'h0000_123C, miss);
    cpu_read("first word", 32'h0000_1230, miss);
    check_bit("cached line hit", 1'b0, miss);

    // Five lines in one set where re-reads steer the PLRU
    for (int i = 0; i < 4; i++) begin
      cpu_read($sformatf("set fill %0d", i), set5_line(i), miss);
    end
    cpu_read("set reread 0", set5_line(0), miss);
    cpu_read("set reread 1", set5_line(1), miss);
    cpu_read("set fifth line", set5_line(4), miss);
    for (int i = 0; i < 5; i++) begin
      cpu_read($sformatf("set late read %0d", i), set5_line(i), miss);
    end

    // Flush request from idle
    flush  = 1'b1;
    cycles = 0;
    while (!flush_busy) begin
      if (cycles >= TIMEOUT_CYC) begin
        stop_run("Timeout: flush request never started a sweep");
      end
      @(posedge clk);
      @(negedge clk);
      cycles++;
    end
    flush = 1'b0;
    clear_model();
    measure_sweep("flush sweep", cycles);
    check_eq("flush sweep length", icache_pkg::NUM_SET, cycles);

    cpu_read("after flush line", 32'h0000_1234, miss);
    check_bit("after flush line miss", 1'b1, miss);
    for (int i = 0; i < 5; i++) begin
      cpu_read($sformatf("after flush set %0d", i), set5_line(i), miss);
      check_bit("after flush set miss", 1'b1, miss);
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/icache_chk.sv ====
// Handshake and sweep assertions, bound to the cache top level
`timescale 1ns/1ps
`default_nettype none

module icache_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic cpu_req_valid_i,
  input logic cpu_ack_i,
  input logic mem_req_valid_i,
  input logic mem_ack_i,
  input logic flush_busy_i
);

  // ==============================
  // Memory side
  // ==============================
  // Request stays up until the memory answers
  mem_req_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_i && !mem_ack_i |=> mem_req_valid_i
  ) else $error("memory request dropped before its ack");

  // Line captured on the first ack cycle, request gone after it
  mem_req_release_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_i && mem_ack_i |=> !mem_req_valid_i
  ) else $error("memory request still up after the ack");

  // ==============================
  // CPU side
  // ==============================
  cpu_ack_cause_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(cpu_ack_i) |-> $past(cpu_req_valid_i)
  ) else $error("CPU ack rose without a request");

  // Ack falls exactly one cycle after the request
  cpu_ack_release_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(cpu_req_valid_i) |=> $fell(cpu_ack_i)
  ) else $error("CPU ack did not fall one cycle after the request");

  // Nothing moves on either bus during the sweep
  sweep_quiet_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    flush_busy_i |-> !cpu_ack_i && !mem_req_valid_i
  ) else $error("handshake active during the invalidate sweep");

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
// Instruction cache top level, CPU and memory sides both four-phase req/ack
// Joins the controller, the sweep counter and the tag, data and PLRU stores
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cpu_req_valid_i,
  input  icache_pkg::cpu_req_t cpu_req_i,
  output logic                 cpu_ack_o,
  output icache_pkg::cpu_rsp_t cpu_rsp_o,
  output logic                 mem_req_valid_o,
  output icache_pkg::mem_req_t mem_req_o,
  input  logic                 mem_ack_i,
  input  icache_pkg::line_t    mem_line_i,
  input  logic                 flush_i,
  output logic                 flush_busy_o
);

  // Controller to store steering
  icache_pkg::idx_t      array_idx;
  icache_pkg::tag_t      lookup_tag;
  icache_pkg::word_sel_t word_sel;
  icache_pkg::way_vec_t  fill_way;
  icache_pkg::way_vec_t  touch_way;
  logic                  fill_en;
  logic                  clear_en;
  logic                  touch_en;
  logic                  load_hit;
  logic                  load_fill;
  // Store results back to the controller
  icache_pkg::way_vec_t  hit_way;
  icache_pkg::way_vec_t  valid_way;
  icache_pkg::way_vec_t  victim_way;
  icache_pkg::word_t     rsp_word;
  logic                  cpu_miss;
  // Sweep counter
  icache_pkg::idx_t      sweep_idx;
  logic                  sweep_en;
  logic                  sweep_last;

  assign cpu_rsp_o = '{data: rsp_word, miss: cpu_miss};

  icache_ctrl ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cpu_req_valid_i(cpu_req_valid_i),
    .cpu_req_i      (cpu_req_i),
    .flush_i        (flush_i),
    .mem_ack_i      (mem_ack_i),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .sweep_idx_i    (sweep_idx),
    .sweep_last_i   (sweep_last),
    .cpu_ack_o      (cpu_ack_o),
    .cpu_miss_o     (cpu_miss),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_o      (mem_req_o),
    .flush_busy_o   (flush_busy_o),
    .sweep_en_o     (sweep_en),
    .array_idx_o    (array_idx),
    .lookup_tag_o   (lookup_tag),
    .word_sel_o     (word_sel),
    .fill_way_o     (fill_way),
    .fill_en_o      (fill_en),
    .clear_en_o     (clear_en),
    .touch_en_o     (touch_en),
    .touch_way_o    (touch_way),
    .load_hit_o     (load_hit),
    .load_fill_o    (load_fill)
  );

  flush_counter sweep_cnt_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .count_en_i(sweep_en),
    .count_o   (sweep_idx),
    .last_o    (sweep_last)
  );

  tag_store tag_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .idx_i       (array_idx),
    .lookup_tag_i(lookup_tag),
    .fill_en_i   (fill_en),
    .fill_way_i  (fill_way),
    .clear_en_i  (clear_en),
    .hit_way_o   (hit_way),
    .valid_way_o (valid_way)
  );

  data_store data_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .idx_i      (array_idx),
    .word_sel_i (word_sel),
    .fill_en_i  (fill_en),
    .fill_way_i (fill_way),
    .fill_line_i(mem_line_i),
    .load_hit_i (load_hit),
    .load_fill_i(load_fill),
    .hit_way_i  (hit_way),
    .rsp_word_o (rsp_word)
  );

  plru_tree plru_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .idx_i       (array_idx),
    .valid_way_i (valid_way),
    .clear_en_i  (clear_en),
    .touch_en_i  (touch_en),
    .touch_way_i (touch_way),
    .victim_way_o(victim_way)
  );

endmodule

`default_nettype wire

// ==== icache_ctrl/icache_ctrl.sv ====
// Cache FSM: sweep, lookup, line refill and both four-phase handshakes
// Owns the request address, the array index and every store write enable
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cpu_req_valid_i,
  input  icache_pkg::cpu_req_t   cpu_req_i,
  input  logic                   flush_i,
  input  logic                   mem_ack_i,
  input  icache_pkg::way_vec_t   hit_way_i,
  input  icache_pkg::way_vec_t   victim_way_i,
  input  icache_pkg::idx_t       sweep_idx_i,
  input  logic                   sweep_last_i,
  output logic                   cpu_ack_o,
  output logic                   cpu_miss_o,
  output logic                   mem_req_valid_o,
  output icache_pkg::mem_req_t   mem_req_o,
  output logic                   flush_busy_o,
  output logic                   sweep_en_o,
  output icache_pkg::idx_t       array_idx_o,
  output icache_pkg::tag_t       lookup_tag_o,
  output icache_pkg::word_sel_t  word_sel_o,
  output icache_pkg::way_vec_t   fill_way_o,
  output logic                   fill_en_o,
  output logic                   clear_en_o,
  output logic                   touch_en_o,
  output icache_pkg::way_vec_t   touch_way_o,
  output logic                   load_hit_o,
  output logic                   load_fill_o
);

  icache_pkg::ctrl_state_e state_q;
  icache_pkg::ctrl_state_e state_d;
  icache_pkg::addr_t       req_addr_q;
  icache_pkg::way_vec_t    fill_way_q;
  logic                    ack_q;
  logic                    mem_req_q;
  logic                    miss_q;
  logic                    lookup_hit;

  assign lookup_hit = |hit_way_i;

  // ==============================
  // Next state
  // ==============================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      icache_pkg::SWEEP: begin
        if (sweep_last_i) begin
          state_d = icache_pkg::IDLE;
        end
      end
      icache_pkg::IDLE: begin
        // Invalidate wins over a waiting request
        if (flush_i) begin
          state_d = icache_pkg::SWEEP;
        end else if (cpu_req_valid_i) begin
          state_d = icache_pkg::LOOKUP;
        end
      end
      icache_pkg::LOOKUP: begin
        state_d = lookup_hit ? icache_pkg::RESPOND : icache_pkg::REFILL;
      end
      icache_pkg::REFILL: begin
        if (mem_ack_i) begin
          state_d = icache_pkg::REFILL_END;
        end
      end
      // Memory ack must fall before the CPU sees its answer
      icache_pkg::REFILL_END: begin
        if (!mem_ack_i) begin
          state_d = icache_pkg::RESPOND;
        end
      end
      icache_pkg::RESPOND: begin
        if (!cpu_req_valid_i) begin
          state_d = icache_pkg::IDLE;
        end
      end
      default: state_d = icache_pkg::IDLE;
    endcase
  end

  // Handshake outputs are registered, one cycle behind the state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= icache_pkg::SWEEP;
      ack_q     <= 1'b0;
      mem_req_q <= 1'b0;
      miss_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      ack_q     <= (state_q == icache_pkg::RESPOND) && cpu_req_valid_i;
      // Held until the first ack cycle
      mem_req_q <= (state_q == icache_pkg::REFILL) && !mem_ack_i;
      if (state_q == icache_pkg::LOOKUP) begin
        miss_q <= !lookup_hit;
      end
    end
  end

  // Request address and chosen victim
  always_ff @(posedge clk_i) begin
    if (state_q == icache_pkg::IDLE && cpu_req_valid_i) begin
      req_addr_q <= cpu_req_i.addr;
    end
    if (state_q == icache_pkg::LOOKUP) begin
      fill_way_q <= victim_way_i;
    end
  end

  // Array index: sweep counter, incoming address in IDLE, held address otherwise
  always_comb begin
    if (state_q == icache_pkg::SWEEP) begin
      array_idx_o = sweep_idx_i;
    end else if (state_q == icache_pkg::IDLE) begin
      array_idx_o = cpu_req_i.addr[icache_pkg::BYTE_OFF_W +: icache_pkg::IDX_W];
    end else begin
      array_idx_o = req_addr_q[icache_pkg::BYTE_OFF_W +: icache_pkg::IDX_W];
    end
  end

  assign lookup_tag_o = req_addr_q[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  assign word_sel_o   = req_addr_q[icache_pkg::BYTE_OFF_W-1 -: icache_pkg::WORD_SEL_W];

  // ==============================
  // Store enables
  // ==============================
  assign sweep_en_o  = (state_q == icache_pkg::SWEEP);
  assign clear_en_o  = sweep_en_o;
  assign load_hit_o  = (state_q == icache_pkg::LOOKUP) && lookup_hit;
  // Line lands on the first memory ack cycle
  assign fill_en_o   = (state_q == icache_pkg::REFILL) && mem_ack_i;
  assign load_fill_o = fill_en_o;
  assign fill_way_o  = fill_way_q;
  assign touch_en_o  = load_hit_o || fill_en_o;
  assign touch_way_o = (state_q == icache_pkg::LOOKUP) ? hit_way_i : fill_way_q;

  assign cpu_ack_o       = ack_q;
  assign cpu_miss_o      = miss_q;
  assign mem_req_valid_o = mem_req_q;
  assign flush_busy_o    = sweep_en_o;
  assign mem_req_o       = '{line_addr: {req_addr_q[icache_pkg::ADDR_W-1:icache_pkg::BYTE_OFF_W],
                                         {icache_pkg::BYTE_OFF_W{1'b0}}}};

endmodule

`default_nettype wire

// ==== cache_arrays/plru_tree.sv ====
// Tree pseudo-LRU bits per set, victim choice and update on hit or fill
`timescale 1ns/1ps
`default_nettype none

module plru_tree (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  icache_pkg::idx_t     idx_i,
  input  icache_pkg::way_vec_t valid_way_i,
  input  logic                 clear_en_i,
  input  logic                 touch_en_i,
  input  icache_pkg::way_vec_t touch_way_i,
  output icache_pkg::way_vec_t victim_way_o
);

  icache_pkg::plru_node_t node_mem [icache_pkg::NUM_SET];
  icache_pkg::plru_node_t node_q;

  // Heap order: node 0 is the root, children of n are 2n+1 and 2n+2
  // A node bit of 0 points at the lower half
  function automatic icache_pkg::way_vec_t tree_victim(input icache_pkg::plru_node_t node);
    int n;
    icache_pkg::way_vec_t way;
    n = 0;
    for (int l = 0; l < $clog2(icache_pkg::NUM_WAY); l++) begin
      n = 2 * n + 1 + int'(node[n]);
    end
    way = '0;
    way[n - icache_pkg::NODE_W] = 1'b1;
    return way;
  endfunction

  // Every bit on the path is turned away from the touched way
  function automatic icache_pkg::plru_node_t tree_touch(input icache_pkg::plru_node_t node,
                                                        input icache_pkg::way_vec_t   way);
    int n;
    int w;
    logic b;
    icache_pkg::plru_node_t nxt;
    w = 0;
    for (int i = 0; i < icache_pkg::NUM_WAY; i++) begin
      if (way[i]) begin
        w = i;
      end
    end
    nxt = node;
    n = 0;
    for (int l = $clog2(icache_pkg::NUM_WAY) - 1; l >= 0; l--) begin
      b = w[l];
      nxt[n] = ~b;
      n = 2 * n + 1 + int'(b);
    end
    return nxt;
  endfunction

  // Touch uses the bits read last cycle for the same set
  always_ff @(posedge clk_i) begin
    if (clear_en_i) begin
      node_mem[idx_i] <= '0;
    end else if (touch_en_i) begin
      node_mem[idx_i] <= tree_touch(node_q, touch_way_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      node_q <= '0;
    end else begin
      node_q <= node_mem[idx_i];
    end
  end

  // Lowest invalid way first, the tree only when the set is full
  always_comb begin
    victim_way_o = tree_victim(node_q);
    for (int w = icache_pkg::NUM_WAY - 1; w >= 0; w--) begin
      if (!valid_way_i[w]) begin
        victim_way_o = icache_pkg::way_vec_t'(1) << w;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cache_arrays/data_store.sv ====
// Per-way line arrays, word extraction and the CPU response word register
`timescale 1ns/1ps
`default_nettype none

module data_store (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  icache_pkg::idx_t      idx_i,
  input  icache_pkg::word_sel_t word_sel_i,
  input  logic                  fill_en_i,
  input  icache_pkg::way_vec_t  fill_way_i,
  input  icache_pkg::line_t     fill_line_i,
  input  logic                  load_hit_i,
  input  logic                  load_fill_i,
  input  icache_pkg::way_vec_t  hit_way_i,
  output icache_pkg::word_t     rsp_word_o
);

  icache_pkg::line_t line_mem [icache_pkg::NUM_WAY][icache_pkg::NUM_SET];
  icache_pkg::line_t line_q   [icache_pkg::NUM_WAY];
  icache_pkg::word_t hit_word;
  icache_pkg::word_t rsp_q;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < icache_pkg::NUM_WAY; w++) begin
      if (fill_en_i && fill_way_i[w]) begin
        line_mem[w][idx_i] <= fill_line_i;
      end
      line_q[w] <= line_mem[w][idx_i];
    end
  end

  // Hit vector is one-hot, so an OR of masked words selects it
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < icache_pkg::NUM_WAY; w++) begin
      if (hit_way_i[w]) begin
        hit_word = hit_word | line_q[w][word_sel_i*icache_pkg::WORD_W +: icache_pkg::WORD_W];
      end
    end
  end

  // Refill answers straight from the incoming line
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else if (load_hit_i) begin
      rsp_q <= hit_word;
    end else if (load_fill_i) begin
      rsp_q <= fill_line_i[word_sel_i*icache_pkg::WORD_W +: icache_pkg::WORD_W];
    end
  end

  assign rsp_word_o = rsp_q;

endmodule

`default_nettype wire

// ==== cache_arrays/tag_store.sv ====
// Per-way tag and valid arrays with one-cycle read and hit compare
`timescale 1ns/1ps
`default_nettype none

module tag_store (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  icache_pkg::idx_t     idx_i,
  input  icache_pkg::tag_t     lookup_tag_i,
  input  logic                 fill_en_i,
  input  icache_pkg::way_vec_t fill_way_i,
  input  logic                 clear_en_i,
  output icache_pkg::way_vec_t hit_way_o,
  output icache_pkg::way_vec_t valid_way_o
);

  icache_pkg::tag_t     tag_mem   [icache_pkg::NUM_WAY][icache_pkg::NUM_SET];
  icache_pkg::way_vec_t valid_mem [icache_pkg::NUM_SET];
  icache_pkg::tag_t     tag_q     [icache_pkg::NUM_WAY];
  icache_pkg::way_vec_t valid_q;

  // Tag write on fill, registered read of every way
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < icache_pkg::NUM_WAY; w++) begin
      if (fill_en_i && fill_way_i[w]) begin
        tag_mem[w][idx_i] <= lookup_tag_i;
      end
      tag_q[w] <= tag_mem[w][idx_i];
    end
  end

  // Clear drops the whole set, fill marks one way
  always_ff @(posedge clk_i) begin
    if (clear_en_i) begin
      valid_mem[idx_i] <= '0;
    end else if (fill_en_i) begin
      valid_mem[idx_i] <= valid_mem[idx_i] | fill_way_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_mem[idx_i];
    end
  end

  // Hit compare against the held request tag
  always_comb begin
    for (int w = 0; w < icache_pkg::NUM_WAY; w++) begin
      hit_way_o[w] = valid_q[w] && (tag_q[w] == lookup_tag_i);
    end
  end

  assign valid_way_o = valid_q;

endmodule

`default_nettype wire

// ==== hdl/flush_counter.sv ====
// Set index counter for the invalidate sweep, steps one set per enabled cycle
`timescale 1ns/1ps
`default_nettype none

module flush_counter (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             count_en_i,
  output icache_pkg::idx_t count_o,
  output logic             last_o
);

  icache_pkg::idx_t count_q;

  // Wraps to set 0 so the next sweep starts clean
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (count_en_i) begin
      if (last_o) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign count_o = count_q;
  // Final set of the sweep
  assign last_o  = (count_q == icache_pkg::idx_t'(icache_pkg::NUM_SET - 1));

endmodule

`default_nettype wire

// ==== common/icache_pkg.sv ====
// Geometry, width types, bus structs and controller states of the instruction cache
// All cache modules refer to these by scoped name
`default_nettype none

package icache_pkg;

  // ==============================
  // Geometry
  // ==============================
  localparam int ADDR_W  = 32;
  localparam int WORD_W  = 32;
  localparam int LINE_W  = 128;
  localparam int NUM_WAY = 4;
  localparam int NUM_SET = 16;

  // Derived field widths of a byte address
  localparam int WORD_SEL_W = $clog2(LINE_W / WORD_W);
  localparam int IDX_W      = $clog2(NUM_SET);
  localparam int BYTE_OFF_W = $clog2(LINE_W / 8);
  localparam int TAG_W      = ADDR_W - IDX_W - BYTE_OFF_W;
  // Tree PLRU keeps one bit per inner node
  localparam int NODE_W     = NUM_WAY - 1;

  // ==============================
  // Vector types
  // ==============================
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [IDX_W-1:0]      idx_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;
  // One bit per way, one-hot for hit, victim and fill
  typedef logic [NUM_WAY-1:0]    way_vec_t;
  typedef logic [NODE_W-1:0]     plru_node_t;

  // ==============================
  // Bus structs
  // ==============================
  typedef struct packed {
    addr_t addr;
  } cpu_req_t;

  typedef struct packed {
    word_t data;
    logic  miss;   // Access needed a refill
  } cpu_rsp_t;

  // Line address, offset bits always zero
  typedef struct packed {
    addr_t line_addr;
  } mem_req_t;

  // Controller states, sweep first so reset lands in it
  typedef enum logic [2:0] {
    SWEEP,
    IDLE,
    LOOKUP,
    REFILL,
    REFILL_END,
    RESPOND
  } ctrl_state_e;

endpackage

`default_nettype wire
